/* rtl/led_matrix_config.svh */
// led matrix panel configuration
// panel geometry, colour depth and enable timing constants
`ifndef LED_MATRIX_CONFIG_SVH
`define LED_MATRIX_CONFIG_SVH

// columns per row
`define PIXEL_WIDTH 8

// rows per half panel
// both halves are scanned together
`define PIXEL_HALFHEIGHT 4

// bits per colour channel
`define BRIGHTNESS_LEVELS 3

// enable cycles for the least significant bit plane
`define BRIGHTNESS_BASE_TIMEOUT 4

// remaining enable cycles at which the next line may start shifting
`define BRIGHTNESS_STATE_TIMEOUT_OVERLAP 6

// column index width
`define COLUMN_BITS ($clog2(`PIXEL_WIDTH))

// row index width within one half
`define ROW_BITS ($clog2(`PIXEL_HALFHEIGHT))

// wide enough for the longest enable window
// longest window belongs to the most significant plane
`define ENABLE_BITS \
    ($clog2((`BRIGHTNESS_BASE_TIMEOUT << (`BRIGHTNESS_LEVELS - 1)) + 1))

`endif

/* rtl/led_matrix_pkg.sv */
// led matrix shared types
// colour words, write requests, scan position and panel pins
`default_nettype none

`include "led_matrix_config.svh"

package led_matrix_pkg;

    // one-hot bit plane select
    typedef logic [`BRIGHTNESS_LEVELS-1:0] brightness_level_t;

    // one colour word per pixel
    typedef struct packed {
        logic [`BRIGHTNESS_LEVELS-1:0] r;
        logic [`BRIGHTNESS_LEVELS-1:0] g;
        logic [`BRIGHTNESS_LEVELS-1:0] b;
    } color_t;

    // write request into the frame store
    // row covers the full panel height
    typedef struct packed {
        logic [`ROW_BITS:0]         row;
        logic [`COLUMN_BITS-1:0]    column;
        color_t                     color;
    } pixel_write_t;

    // position the sequencer is currently loading
    typedef struct packed {
        logic [`COLUMN_BITS-1:0]    column;
        logic [`ROW_BITS-1:0]       row;
        brightness_level_t          mask;
    } scan_pos_t;

    // hub75 panel pins
    typedef struct packed {
        logic r0;
        logic g0;
        logic b0;
        logic r1;
        logic g1;
        logic b1;
        logic shift;
        logic latch;
        // high means leds lit
        logic output_enable;
        logic [`ROW_BITS-1:0] row_address;
    } hub75_t;

endpackage

`default_nettype wire

/* rtl/scan_timeout.sv */
// loadable down-counter
// counts from the loaded value to zero and flags while running
`timescale 1ns/1ps
`default_nettype none

module scan_timeout #(
    parameter int COUNTER_WIDTH = 4
) (
    input  wire logic                     clk_in,
    input  wire logic                     reset,
    input  wire logic                     start,
    input  wire logic [COUNTER_WIDTH-1:0] value,
    output logic      [COUNTER_WIDTH-1:0] counter,
    output logic                          running
);

    // running stays high for value + 1 cycles
    always_ff @(posedge clk_in) begin
        if (reset) begin
            counter <= '0;
            running <= 1'b0;
        end else if (start) begin
            // reload even when already running
            counter <= value;
            running <= 1'b1;
        end else if (running) begin
            if (counter == '0) begin
                // count hit zero last cycle so the timer stops
                running <= 1'b0;
            end else begin
                counter <= counter - 1'b1;
            end
        end
    end

    // counter only ever moves down while running without a reload
    assert property (@(posedge clk_in) disable iff (reset)
        (running && !start) |=> (counter <= $past(counter)))
    else $error("scan_timeout: counter wrapped past zero");

endmodule

`default_nettype wire

/* rtl/brightness_timeout.sv */
// bit-weighted output enable window
// base time shifted by the active plane index, with overlap flag
`timescale 1ns/1ps
`default_nettype none

`include "led_matrix_config.svh"

module brightness_timeout
    import led_matrix_pkg::*;
(
    input  wire logic        clk_in,
    input  wire logic        reset,
    input  wire logic        latch,
    input  brightness_level_t mask_active,
    output logic             output_enable,
    output logic             exceeded_overlap
);

    // window length minus one, timer runs value + 1 cycles
    logic [`ENABLE_BITS-1:0] window_value;
    // cycles left in the window, minus one
    logic [`ENABLE_BITS-1:0] remaining;
    logic [`ENABLE_BITS-1:0] plane_index;
    logic [`ENABLE_BITS-1:0] window_weight;

    // one-hot mask to bit index
    always_comb begin
        plane_index = '0;
        for (int i = 0; i < `BRIGHTNESS_LEVELS; i++) begin
            if (mask_active[i]) begin
                plane_index = `ENABLE_BITS'(i);
            end
        end
    end

    // binary weighted time per plane
    always_comb begin
        window_weight = `ENABLE_BITS'(`BRIGHTNESS_BASE_TIMEOUT) << plane_index;
        window_value  = window_weight - 1'b1;
    end

    // window opens the cycle after latch
    // a new latch restarts it at the new weight
    scan_timeout #(
        .COUNTER_WIDTH(`ENABLE_BITS)
    ) enable_timer (
        .clk_in (clk_in),
        .reset  (reset),
        .start  (latch),
        .value  (window_value),
        .counter(remaining),
        .running(output_enable)
    );

    // remaining + 1 lit cycles at or below the margin
    assign exceeded_overlap = output_enable
        && (int'(remaining) < `BRIGHTNESS_STATE_TIMEOUT_OVERLAP);

    // weight lookup only makes sense for a single plane
    assert property (@(posedge clk_in) disable iff (reset)
        latch |-> $onehot(mask_active))
    else $error("brightness_timeout: mask_active 0x%0h not one-hot at latch",
                mask_active);

endmodule

`default_nettype wire

/* rtl/pixel_feed.sv */
// frame store and bit plane select
// holds one colour word per pixel and feeds the two half rows
`timescale 1ns/1ps
`default_nettype none

`include "led_matrix_config.svh"

module pixel_feed
    import led_matrix_pkg::*;
(
    input  wire logic         clk_in,
    input  wire logic         reset,
    input  pixel_write_t      pixel_write,
    input  wire logic         pixel_write_valid,
    input  scan_pos_t         scan_pos,
    input  wire logic         pixel_load,
    output logic [2:0]        upper_rgb,
    output logic [2:0]        lower_rgb
);

    localparam int FULL_HEIGHT = 2 * `PIXEL_HALFHEIGHT;

    // full panel, rows 0 to FULL_HEIGHT-1
    color_t frame [FULL_HEIGHT][`PIXEL_WIDTH];

    logic [`ROW_BITS:0] upper_row;
    logic [`ROW_BITS:0] lower_row;
    color_t             upper_color;
    color_t             lower_color;

    // masked bit of each channel, r in bit 2
    function automatic logic [2:0] plane_bits(color_t c, brightness_level_t m);
        logic [2:0] bits;
        bits[2] = |(c.r & m);
        bits[1] = |(c.g & m);
        bits[0] = |(c.b & m);
        return bits;
    endfunction

    // write port, lands at the next edge
    always_ff @(posedge clk_in) begin
        if (pixel_write_valid) begin
            frame[pixel_write.row][pixel_write.column] <= pixel_write.color;
        end
    end

    // lower half sits PIXEL_HALFHEIGHT rows down
    assign upper_row = {1'b0, scan_pos.row};
    assign lower_row = upper_row + (`ROW_BITS + 1)'(`PIXEL_HALFHEIGHT);

    assign upper_color = frame[upper_row][scan_pos.column];
    assign lower_color = frame[lower_row][scan_pos.column];

    // bits valid one cycle after pixel_load, lined up with shift
    always_ff @(posedge clk_in) begin
        if (reset) begin
            upper_rgb <= '0;
            lower_rgb <= '0;
        end else if (pixel_load) begin
            upper_rgb <= plane_bits(upper_color, scan_pos.mask);
            lower_rgb <= plane_bits(lower_color, scan_pos.mask);
        end
    end

endmodule

`default_nettype wire

/* rtl/matrix_scan.sv */
// led matrix scan sequencer
// steps column, row and bit plane, and drives load, shift, latch and enable
`timescale 1ns/1ps
`default_nettype none

`include "led_matrix_config.svh"

module matrix_scan
    import led_matrix_pkg::*;
(
    input  wire logic              clk_in,
    input  wire logic              reset,
    output scan_pos_t              scan_pos,
    output logic                   pixel_load,
    output logic                   shift,
    output logic                   latch,
    output logic [`ROW_BITS-1:0]   row_address,
    output logic                   output_enable
);

    localparam brightness_level_t MASK_MSB = brightness_level_t'(1) << (`BRIGHTNESS_LEVELS - 1);

    // line being loaded
    logic [`COLUMN_BITS-1:0] column;
    logic [`ROW_BITS-1:0]    row_loaded;
    brightness_level_t       mask_loaded;

    // line being displayed
    logic [`ROW_BITS-1:0]    row_active;
    brightness_level_t       mask_active_q;
    brightness_level_t       mask_active;

    logic start_strobe;
    logic shifter_idle;
    logic advance;
    logic exceeded_overlap;

    // display dark or nearly done
    assign advance = !output_enable || exceeded_overlap;

    // nothing in flight from start strobe to latch
    assign shifter_idle = !start_strobe && !pixel_load && !shift && !latch;

    always_ff @(posedge clk_in) begin
        if (reset) begin
            start_strobe <= 1'b0;
        end else begin
            start_strobe <= advance && shifter_idle;
        end
    end

    // column counter
    // pixel_load high for PIXEL_WIDTH cycles, column counting down
    scan_timeout #(
        .COUNTER_WIDTH(`COLUMN_BITS)
    ) column_timer (
        .clk_in (clk_in),
        .reset  (reset),
        .start  (start_strobe),
        .value  (`COLUMN_BITS'(`PIXEL_WIDTH - 1)),
        .counter(column),
        .running(pixel_load)
    );

    // shift trails load by one, pixel data is registered downstream
    // latch one cycle after the final shift
    always_ff @(posedge clk_in) begin
        if (reset) begin
            shift <= 1'b0;
            latch <= 1'b0;
        end else begin
            shift <= pixel_load;
            latch <= shift && !pixel_load;
        end
    end

    // mask and row stepping
    always_ff @(posedge clk_in) begin
        if (reset) begin
            row_loaded    <= '0;
            mask_loaded   <= MASK_MSB;
            row_active    <= '0;
            mask_active_q <= MASK_MSB;
        end else if (latch) begin
            row_active    <= row_loaded;
            mask_active_q <= mask_loaded;
            if (mask_loaded[0]) begin
                // last plane of this row, wrap to msb and move on
                mask_loaded <= MASK_MSB;
                if (row_loaded == `ROW_BITS'(`PIXEL_HALFHEIGHT - 1)) begin
                    row_loaded <= '0;
                end else begin
                    row_loaded <= row_loaded + 1'b1;
                end
            end else begin
                mask_loaded <= mask_loaded >> 1;
            end
        end
    end

    // bypass during latch
    // timer needs the plane just shifted, register updates one edge later
    assign mask_active = latch ? mask_loaded : mask_active_q;

    brightness_timeout enable_window (
        .clk_in          (clk_in),
        .reset           (reset),
        .latch           (latch),
        .mask_active     (mask_active),
        .output_enable   (output_enable),
        .exceeded_overlap(exceeded_overlap)
    );

    assign scan_pos = '{column: column, row: row_loaded, mask: mask_loaded};
    assign row_address = row_active;

    // latch must not cut into a line still loading
    assert property (@(posedge clk_in) disable iff (reset)
        !(pixel_load && latch))
    else $error("matrix_scan: pixel_load overlaps latch");

endmodule

`default_nettype wire

/* rtl/led_matrix_top.sv */
// led matrix driver top level
// joins the scan sequencer and frame store onto the hub75 pins
`timescale 1ns/1ps
`default_nettype none

`include "led_matrix_config.svh"

module led_matrix_top
    import led_matrix_pkg::*;
(
    input  wire logic   clk_in,
    input  wire logic   reset,
    input  pixel_write_t pixel_write,
    input  wire logic   pixel_write_valid,
    output hub75_t      panel
);

    scan_pos_t             scan_pos;
    logic                  pixel_load;
    logic                  shift;
    logic                  latch;
    logic                  output_enable;
    logic [`ROW_BITS-1:0]  row_address;
    logic [2:0]            upper_rgb;
    logic [2:0]            lower_rgb;

    matrix_scan scan (
        .clk_in       (clk_in),
        .reset        (reset),
        .scan_pos     (scan_pos),
        .pixel_load   (pixel_load),
        .shift        (shift),
        .latch        (latch),
        .row_address  (row_address),
        .output_enable(output_enable)
    );

    pixel_feed feed (
        .clk_in           (clk_in),
        .reset            (reset),
        .pixel_write      (pixel_write),
        .pixel_write_valid(pixel_write_valid),
        .scan_pos         (scan_pos),
        .pixel_load       (pixel_load),
        .upper_rgb        (upper_rgb),
        .lower_rgb        (lower_rgb)
    );

    // rgb bits ordered r, g, b
    assign panel = '{r0: upper_rgb[2], g0: upper_rgb[1], b0: upper_rgb[0],
                     r1: lower_rgb[2], g1: lower_rgb[1], b1: lower_rgb[0],
                     shift: shift, latch: latch, output_enable: output_enable,
                     row_address: row_address};

endmodule

`default_nettype wire

/* tb/led_matrix_checks.sv */
// led matrix panel checks bound into the top level
// frame model, scan order tracking and concurrent assertions on the panel pins
`timescale 1ns/1ps
`default_nettype none

`include "led_matrix_config.svh"

module led_matrix_checks
    import led_matrix_pkg::*;
(
    input  wire logic   clk_in,
    input  wire logic   reset,
    input  pixel_write_t pixel_write,
    input  wire logic   pixel_write_valid,
    input  hub75_t      panel
);

    localparam int W = `PIXEL_WIDTH;
    localparam int H = `PIXEL_HALFHEIGHT;
    localparam int L = `BRIGHTNESS_LEVELS;

    // mirror of the frame store filled from the write port
    color_t model [2*H][W];
    bit     written [2*H][W];

    // position of the pixel behind the current or coming shift
    int col;
    int row;
    int plane;
    int next_col;
    int next_row;
    int next_plane;
    // segment bookkeeping
    int shift_count;
    int oe_left;
    int last_row;
    int last_plane;
    int lit_row;
    logic last_was_shift;
    logic reset_seen;
    logic reset_seen2;
    bit exp_known;
    logic [5:0] exp_rgb;
    logic [5:0] panel_rgb;
    color_t upper_color;
    color_t lower_color;

    // pass counts per behavior read by the testbench top
    int reset_checks;
    int latch_checks;
    int data_checks;
    int row_checks;
    int enable_checks;
    int error_count;

    assign panel_rgb = {panel.r0, panel.g0, panel.b0, panel.r1, panel.g1, panel.b1};

    // column counts down and plane steps msb to lsb before the row moves on
    always_comb begin
        next_col = col;
        next_row = row;
        next_plane = plane;
        if (panel.shift) begin
            next_col = (col == 0) ? W - 1 : col - 1;
            if (col == 0) begin
                next_plane = (plane == 0) ? L - 1 : plane - 1;
                if (plane == 0) begin
                    next_row = (row + 1) % H;
                end
            end
        end
    end

    // lower half sits H rows below the upper one
    assign upper_color = model[next_row][next_col];
    assign lower_color = model[next_row + H][next_col];

    always @(posedge clk_in) begin
        reset_seen <= reset;
        reset_seen2 <= reset_seen;
        if (pixel_write_valid) begin
            model[pixel_write.row][pixel_write.column] <= pixel_write.color;
            written[pixel_write.row][pixel_write.column] <= 1'b1;
        end
        if (reset) begin
            col <= W - 1;
            row <= 0;
            plane <= L - 1;
            shift_count <= 0;
            oe_left <= 0;
            last_row <= 0;
            last_plane <= L - 1;
            lit_row <= 0;
            last_was_shift <= 1'b0;
            exp_known <= 1'b0;
        end else begin
            col <= next_col;
            row <= next_row;
            plane <= next_plane;
            // frame as it stands at this edge is seen on the next shift
            exp_rgb <= {upper_color.r[next_plane], upper_color.g[next_plane],
                        upper_color.b[next_plane], lower_color.r[next_plane],
                        lower_color.g[next_plane], lower_color.b[next_plane]};
            exp_known <= written[next_row][next_col] && written[next_row + H][next_col];
            last_was_shift <= panel.shift;
            if (panel.shift) begin
                last_row <= row;
                last_plane <= plane;
            end
            if (panel.latch) begin
                shift_count <= 0;
                lit_row <= last_row;
                // window weight doubles per plane
                oe_left <= `BRIGHTNESS_BASE_TIMEOUT << last_plane;
            end else begin
                if (panel.shift) begin
                    shift_count <= shift_count + 1;
                end
                if (oe_left > 0) begin
                    oe_left <= oe_left - 1;
                end
            end
        end
    end

    // checks sample on the falling edge where the pins have settled
    assert property (@(negedge clk_in) (reset_seen || reset_seen2) |->
        !(panel.shift || panel.latch || panel.output_enable)) begin
        if (reset_seen || reset_seen2) reset_checks++;
    end else begin
        error_count++;
        $error("mismatch shift_latch_oe expected 0x0 got 0x%0h",
               {panel.shift, panel.latch, panel.output_enable});
    end

    assert property (@(negedge clk_in) disable iff (reset_seen)
        panel.latch |-> (last_was_shift && shift_count == W)) begin
        if (panel.latch) latch_checks++;
    end else begin
        error_count++;
        $error("mismatch shift_count expected 0x%0h got 0x%0h with shift just before %0b",
               W, shift_count, last_was_shift);
    end

    // end of a shift run must be the latch cycle
    assert property (@(negedge clk_in) disable iff (reset_seen)
        (last_was_shift && !panel.shift) |-> panel.latch)
    else begin
        error_count++;
        $error("latch did not follow the last shift by one cycle");
    end

    assert property (@(negedge clk_in) disable iff (reset_seen)
        (panel.shift && exp_known) |-> (panel_rgb == exp_rgb)) begin
        if (panel.shift && exp_known) data_checks++;
    end else begin
        error_count++;
        $error("mismatch panel_rgb expected 0x%0h got 0x%0h", exp_rgb, panel_rgb);
    end

    assert property (@(negedge clk_in) disable iff (reset_seen)
        int'(panel.row_address) == lit_row) begin
        row_checks++;
    end else begin
        error_count++;
        $error("mismatch row_address expected 0x%0h got 0x%0h", lit_row, panel.row_address);
    end

    assert property (@(negedge clk_in) disable iff (reset_seen)
        panel.output_enable == (oe_left != 0)) begin
        enable_checks++;
    end else begin
        error_count++;
        $error("mismatch output_enable expected 0x%0h got 0x%0h",
               oe_left != 0, panel.output_enable);
    end

    // next line may only start once the window is nearly spent
    assert property (@(negedge clk_in) disable iff (reset_seen)
        (panel.shift && !last_was_shift) |-> (oe_left <= `BRIGHTNESS_STATE_TIMEOUT_OVERLAP))
    else begin
        error_count++;
        $error("line started shifting with %0d enable cycles still left", oe_left);
    end

endmodule

`default_nettype wire

/* tb/led_matrix_tb.sv */
// led matrix driver testbench
// fills the frame through write strobes and scans two full frames
`timescale 1ns/1ps
`default_nettype none

`include "led_matrix_config.svh"

module led_matrix_tb
    import led_matrix_pkg::*;
();

    localparam int W = `PIXEL_WIDTH;
    localparam int H = `PIXEL_HALFHEIGHT;
    localparam int L = `BRIGHTNESS_LEVELS;
    localparam int ROW_W = `ROW_BITS + 1;
    // shift and latch overhead per segment plus every enable window of a frame
    localparam int FRAME_CYCLES =
        H * (L * (W + 4) + `BRIGHTNESS_BASE_TIMEOUT * ((1 << L) - 1));
    // two frames with half again as margin
    localparam int CYCLE_LIMIT = 2 * FRAME_CYCLES * 3 / 2;
    localparam int RUN_LATCHES = 2 * H * L;

    logic         clk_in;
    logic         reset;
    pixel_write_t pixel_write;
    logic         pixel_write_valid;
    hub75_t       panel;

    logic [31:0] lcg_state;
    int cycle_count;
    int latch_count;
    int fill_index;
    int check_total;
    bit failed;

    led_matrix_top UUT (
        .clk_in           (clk_in),
        .reset            (reset),
        .pixel_write      (pixel_write),
        .pixel_write_valid(pixel_write_valid),
        .panel            (panel)
    );

    bind led_matrix_top led_matrix_checks checks (.*);

    function automatic logic [31:0] lcg_next(logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    initial clk_in = 1'b0;
    always #10 clk_in = ~clk_in;

    // run length in cycles and latches
    always @(posedge clk_in) begin
        if (reset) begin
            cycle_count <= 0;
            latch_count <= 0;
        end else begin
            cycle_count <= cycle_count + 1;
            if (panel.latch) begin
                latch_count <= latch_count + 1;
            end
        end
    end

    // full fill in row order first, then random pixels at random cycles
    task automatic drive_write();
        lcg_state = lcg_next(lcg_state);
        pixel_write.color = lcg_state[16 +: $bits(color_t)];
        if (fill_index < 2 * H * W) begin
            pixel_write.row = ROW_W'(fill_index / W);
            pixel_write.column = `COLUMN_BITS'(fill_index % W);
            pixel_write_valid = 1'b1;
            fill_index++;
        end else begin
            pixel_write.row = lcg_state[25 +: ROW_W];
            pixel_write.column = lcg_state[28 +: `COLUMN_BITS];
            pixel_write_valid = lcg_state[31];
        end
    endtask

    // one line per behavior, one that never ran counts as failed
    task automatic summarize_behavior(string name, int passed);
        if (passed == 0) begin
            $display("test %s: never exercised", name);
            failed = 1'b1;
        end else begin
            $display("test %s: %0d checks passed", name, passed);
        end
        check_total += passed;
    endtask

    initial begin
        reset = 1'b1;
        pixel_write = '0;
        pixel_write_valid = 1'b0;
        lcg_state = 32'h2773;
        fill_index = 0;
        check_total = 0;
        failed = 1'b0;
        repeat (8) @(posedge clk_in);
        @(negedge clk_in);
        reset = 1'b0;
        while (latch_count < RUN_LATCHES && cycle_count < CYCLE_LIMIT) begin
            drive_write();
            @(negedge clk_in);
        end
        pixel_write_valid = 1'b0;
        if (latch_count < RUN_LATCHES) begin
            $display("run timed out after %0d cycles with %0d of %0d latches seen",
                     cycle_count, latch_count, RUN_LATCHES);
            failed = 1'b1;
        end
        summarize_behavior("reset state", UUT.checks.reset_checks);
        summarize_behavior("shift count and latch", UUT.checks.latch_checks);
        summarize_behavior("pixel data", UUT.checks.data_checks);
        summarize_behavior("row address", UUT.checks.row_checks);
        summarize_behavior("enable window", UUT.checks.enable_checks);
        $display("checks passed: %0d, errors: %0d", check_total, UUT.checks.error_count);
        if (failed || UUT.checks.error_count != 0) begin
            $display(">>> FAIL");
        end else begin
            $display(">>> PASS");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
+incdir+rtl
rtl/led_matrix_pkg.sv
rtl/scan_timeout.sv
rtl/brightness_timeout.sv
rtl/pixel_feed.sv
rtl/matrix_scan.sv
rtl/led_matrix_top.sv
tb/led_matrix_checks.sv
tb/led_matrix_tb.sv

/* Makefile */
# Verilator build and run of the led matrix driver testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal -f files.f \
		--top-module led_matrix_tb -Mdir obj_dir -o led_matrix_sim
	./obj_dir/led_matrix_sim | tee sim.log
	@grep -qx ">>> PASS" sim.log || (echo "simulation failed"; exit 1)

clean:
	rm -rf obj_dir sim.log
